// File: hw/io_pkg.sv
// IO subsystem shared definitions
// Bus widths, data and address types, and request opcodes
package io_pkg;

    // Width of one IO data word on the external bus
    localparam int IO_DATA_WIDTH = 32;

    // Width of an IO address as seen on the external bus
    // The register bank only decodes the low bits of it
    localparam int IO_ADDR_WIDTH = 16;

    // One data word, used for write data from a core and read data back to it
    typedef logic [IO_DATA_WIDTH-1:0] io_data_t;

    // One IO address
    typedef logic [IO_ADDR_WIDTH-1:0] io_addr_t;

    // Request opcode carried with each core request
    // A read returns the selected register value in the response
    // A write stores the data and its response carries a zero read value
    typedef enum logic
    {
        IO_READ  = 1'b0,
        IO_WRITE = 1'b1
    } io_op_t;

endpackage

// File: hw/rr_arbiter.sv
// Round-robin arbiter
// One-hot grant to the first requester at or after a rotating priority pointer
module rr_arbiter #(
    parameter int NUM_REQUESTERS = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [NUM_REQUESTERS-1:0] request,
    output logic [NUM_REQUESTERS-1:0] grant_oh
);

    // The pointer needs at least one bit even for a single requester
    localparam int PTR_WIDTH = (NUM_REQUESTERS > 1) ? $clog2(NUM_REQUESTERS) : 1;

    // Index of the requester with the highest priority this cycle
    logic [PTR_WIDTH-1:0] priority_ptr;

    // Index of this cycle's winner, only meaningful when any_grant is set
    logic [PTR_WIDTH-1:0] winner;
    logic                 any_grant;

    // Search forward from the pointer, wrapping past the top index
    // The first requester found takes the grant
    always_comb
    begin : grant_search
        int candidate;

        grant_oh = '0;
        winner = '0;
        any_grant = 1'b0;
        for (int offset = 0; offset < NUM_REQUESTERS; offset++)
        begin
            candidate = (int'(priority_ptr) + offset) % NUM_REQUESTERS;
            if (!any_grant && request[candidate])
            begin
                grant_oh[candidate] = 1'b1;
                winner = PTR_WIDTH'(candidate);
                any_grant = 1'b1;
            end
        end
    end

    // After every grant the winner drops to the lowest priority
    // A requester that keeps asking is therefore served within NUM_REQUESTERS grants
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            priority_ptr <= '0;
        else if (any_grant)
        begin
            if (winner == PTR_WIDTH'(NUM_REQUESTERS - 1))
                priority_ptr <= '0;
            else
                priority_ptr <= winner + 1'b1;
        end
    end

endmodule

// File: hw/io_interconnect.sv
// IO interconnect between the cores and the shared IO bus
// Arbitrates one request per cycle and returns tagged responses two cycles later
module io_interconnect #(
    parameter int  NUM_CORES        = 4,
    parameter int  THREADS_PER_CORE = 4,
    localparam int CORE_TAG_WIDTH   = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1,
    localparam int THREAD_TAG_WIDTH = (THREADS_PER_CORE > 1) ? $clog2(THREADS_PER_CORE) : 1
) (
    input  logic                        clk,
    input  logic                        reset,

    // Requests from the cores
    input  logic [NUM_CORES-1:0]        request_valid,
    input  io_pkg::io_op_t              request_op [NUM_CORES],
    input  io_pkg::io_addr_t            request_address [NUM_CORES],
    input  io_pkg::io_data_t            request_value [NUM_CORES],
    input  logic [THREAD_TAG_WIDTH-1:0] request_thread [NUM_CORES],
    output logic [NUM_CORES-1:0]        request_ready,

    // External IO bus
    output logic                        io_read_en,
    output logic                        io_write_en,
    output io_pkg::io_addr_t            io_address,
    output io_pkg::io_data_t            io_write_data,
    input  io_pkg::io_data_t            io_read_data,

    // Responses back to the cores
    output logic                        response_valid,
    output logic [CORE_TAG_WIDTH-1:0]   response_core,
    output logic [THREAD_TAG_WIDTH-1:0] response_thread,
    output io_pkg::io_data_t            response_read_value
);

    import io_pkg::*;

    logic [NUM_CORES-1:0]        grant_oh;
    logic                        grant_valid;
    logic [CORE_TAG_WIDTH-1:0]   grant_idx;
    io_op_t                      grant_op;
    logic [THREAD_TAG_WIDTH-1:0] grant_thread;

    // Tags of the request that was on the bus in the previous cycle
    logic                        stage1_valid;
    logic [CORE_TAG_WIDTH-1:0]   stage1_core;
    logic [THREAD_TAG_WIDTH-1:0] stage1_thread;

    generate
        if (NUM_CORES > 1)
        begin : arb_gen
            rr_arbiter #(
                .NUM_REQUESTERS(NUM_CORES)
            ) request_arbiter_i (
                .clk     (clk),
                .reset   (reset),
                .request (request_valid),
                .grant_oh(grant_oh)
            );
        end
        else
        begin : single_gen
            // Nothing to arbitrate with one core
            assign grant_oh = request_valid;
        end
    endgenerate

    // The grant is one-hot, so OR-ing the set bit positions yields its index
    always_comb
    begin
        grant_idx = '0;
        for (int i = 0; i < NUM_CORES; i++)
        begin
            if (grant_oh[i])
                grant_idx = grant_idx | CORE_TAG_WIDTH'(i);
        end
    end

    // The ready pulse consumes the request in the same cycle it goes out on the bus
    assign request_ready = grant_oh;
    assign grant_valid = |grant_oh;

    assign grant_op = request_op[grant_idx];
    assign grant_thread = request_thread[grant_idx];

    // Bus strobes follow the opcode of the granted request
    assign io_read_en = grant_valid && (grant_op == IO_READ);
    assign io_write_en = grant_valid && (grant_op == IO_WRITE);
    assign io_address = request_address[grant_idx];
    assign io_write_data = request_value[grant_idx];

    // Tags ride two stages so they meet the bank's registered read data
    always_ff @(posedge clk)
    begin
        if (grant_valid)
        begin
            stage1_core <= grant_idx;
            stage1_thread <= grant_thread;
        end
        if (stage1_valid)
        begin
            response_core <= stage1_core;
            response_thread <= stage1_thread;
            response_read_value <= io_read_data;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            stage1_valid <= 1'b0;
            response_valid <= 1'b0;
        end
        else
        begin
            stage1_valid <= grant_valid;
            response_valid <= stage1_valid;
        end
    end

endmodule

// File: hw/io_register_bank.sv
// IO register bank on the external bus
// Writable registers with read data registered one cycle after the read strobe
module io_register_bank #(
    parameter int NUM_IO_REGS = 16
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             io_read_en,
    input  logic             io_write_en,
    input  io_pkg::io_addr_t io_address,
    input  io_pkg::io_data_t io_write_data,
    output io_pkg::io_data_t io_read_data
);

    import io_pkg::*;

    localparam int REG_INDEX_WIDTH = (NUM_IO_REGS > 1) ? $clog2(NUM_IO_REGS) : 1;

    io_data_t                   regs [NUM_IO_REGS];
    logic [REG_INDEX_WIDTH-1:0] reg_index;

    // Higher addresses alias onto the bank
    // A power-of-two depth reduces this to the low address bits
    assign reg_index = REG_INDEX_WIDTH'(io_address % NUM_IO_REGS);

    // All registers clear to zero on reset, and a write stores its data at the clock edge
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_IO_REGS; i++)
                regs[i] <= '0;
        end
        else if (io_write_en)
        begin
            regs[reg_index] <= io_write_data;
        end
    end

    // Read data holds the register value as it was before any write in the
    // same cycle, and returns to zero whenever no read was issued
    // The interconnect relies on this for the zero read value of a write
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            io_read_data <= '0;
        else if (io_read_en)
            io_read_data <= regs[reg_index];
        else
            io_read_data <= '0;
    end

endmodule

// File: hw/io_subsystem.sv
// IO subsystem top level
// Joins the core-facing interconnect to the IO register bank over an internal bus
module io_subsystem #(
    parameter int  NUM_CORES        = 4,
    parameter int  THREADS_PER_CORE = 4,
    parameter int  NUM_IO_REGS      = 16,
    localparam int CORE_TAG_WIDTH   = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1,
    localparam int THREAD_TAG_WIDTH = (THREADS_PER_CORE > 1) ? $clog2(THREADS_PER_CORE) : 1
) (
    input  logic                        clk,
    input  logic                        reset,

    // Requests from the cores
    input  logic [NUM_CORES-1:0]        request_valid,
    input  io_pkg::io_op_t              request_op [NUM_CORES],
    input  io_pkg::io_addr_t            request_address [NUM_CORES],
    input  io_pkg::io_data_t            request_value [NUM_CORES],
    input  logic [THREAD_TAG_WIDTH-1:0] request_thread [NUM_CORES],
    output logic [NUM_CORES-1:0]        request_ready,

    // Responses back to the cores
    output logic                        response_valid,
    output logic [CORE_TAG_WIDTH-1:0]   response_core,
    output logic [THREAD_TAG_WIDTH-1:0] response_thread,
    output io_pkg::io_data_t            response_read_value
);

    import io_pkg::*;

    // Internal IO bus, with one master and one target
    logic     io_read_en;
    logic     io_write_en;
    io_addr_t io_address;
    io_data_t io_write_data;
    io_data_t io_read_data;

    io_interconnect #(
        .NUM_CORES       (NUM_CORES),
        .THREADS_PER_CORE(THREADS_PER_CORE)
    ) interconnect_i (
        .clk                (clk),
        .reset              (reset),
        .request_valid      (request_valid),
        .request_op         (request_op),
        .request_address    (request_address),
        .request_value      (request_value),
        .request_thread     (request_thread),
        .request_ready      (request_ready),
        .io_read_en         (io_read_en),
        .io_write_en        (io_write_en),
        .io_address         (io_address),
        .io_write_data      (io_write_data),
        .io_read_data       (io_read_data),
        .response_valid     (response_valid),
        .response_core      (response_core),
        .response_thread    (response_thread),
        .response_read_value(response_read_value)
    );

    io_register_bank #(
        .NUM_IO_REGS(NUM_IO_REGS)
    ) register_bank_i (
        .clk          (clk),
        .reset        (reset),
        .io_read_en   (io_read_en),
        .io_write_en  (io_write_en),
        .io_address   (io_address),
        .io_write_data(io_write_data),
        .io_read_data (io_read_data)
    );

endmodule

// File: sim/io_subsystem_props.sv
// Interconnect properties
// Grant exclusivity and fixed response latency on every io_interconnect instance
module io_subsystem_props #(
    parameter int NUM_CORES = 4
) (
    input logic                 clk,
    input logic                 reset,
    input logic [NUM_CORES-1:0] request_valid,
    input logic [NUM_CORES-1:0] request_ready,
    input logic                 io_read_en,
    input logic                 io_write_en,
    input logic                 response_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // Only one request reaches the bus per cycle
    ready_onehot_a: assert property (@(posedge clk) disable iff (reset)
        $onehot0(request_ready)) else $error("More than one ready bit high");

    // A core is only granted while it asks
    ready_needs_valid_a: assert property (@(posedge clk) disable iff (reset)
        (request_ready & ~request_valid) == '0) else $error("Ready without valid");

    // Every grant gives one response two cycles later, and nothing else does
    grant_to_response_a: assert property (@(posedge clk) disable iff (reset)
        $past(|request_ready, 2) |-> response_valid) else $error("Response missing");
    response_from_grant_a: assert property (@(posedge clk) disable iff (reset)
        response_valid |-> $past(|request_ready, 2)) else $error("Response without grant");

    enables_exclusive_a: assert property (@(posedge clk) disable iff (reset)
        !(io_read_en && io_write_en)) else $error("Read and write enable both high");

endmodule

bind io_interconnect io_subsystem_props #(
    .NUM_CORES(NUM_CORES)
) props_i (
    .clk           (clk),
    .reset         (reset),
    .request_valid (request_valid),
    .request_ready (request_ready),
    .io_read_en    (io_read_en),
    .io_write_en   (io_write_en),
    .response_valid(response_valid)
);

// File: sim/io_subsystem_tb.sv
// IO subsystem testbench
// Applies a request table from all cores and checks grants and responses against models
module io_subsystem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import io_pkg::*;

    localparam int NUM_CORES        = 4;
    localparam int THREADS_PER_CORE = 4;
    localparam int NUM_IO_REGS      = 16;
    localparam int CORE_TAG_WIDTH   = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
    localparam int THREAD_TAG_WIDTH = (THREADS_PER_CORE > 1) ? $clog2(THREADS_PER_CORE) : 1;
    localparam int NUM_STEPS        = 32;
    localparam int RESET_STEPS      = NUM_IO_REGS / NUM_CORES;
    localparam int STEP_TIMEOUT     = 4 * NUM_CORES;
    localparam int DRAIN_TIMEOUT    = 10;

    // One response that a granted request still owes, due in a known cycle
    typedef struct packed {
        logic [THREAD_TAG_WIDTH-1:0] thread;
        io_data_t                    value;
        int                          cycle;
    } expect_t;

    logic                        clk;
    logic                        reset;
    logic [NUM_CORES-1:0]        request_valid;
    io_op_t                      request_op [NUM_CORES];
    io_addr_t                    request_address [NUM_CORES];
    io_data_t                    request_value [NUM_CORES];
    logic [THREAD_TAG_WIDTH-1:0] request_thread [NUM_CORES];
    logic [NUM_CORES-1:0]        request_ready;
    logic                        response_valid;
    logic [CORE_TAG_WIDTH-1:0]   response_core;
    logic [THREAD_TAG_WIDTH-1:0] response_thread;
    io_data_t                    response_read_value;

    // Stimulus table, one row per step with a field set for every core
    logic [NUM_CORES-1:0]        step_mask [NUM_STEPS];
    io_op_t                      step_op [NUM_STEPS][NUM_CORES];
    io_addr_t                    step_address [NUM_STEPS][NUM_CORES];
    io_data_t                    step_value [NUM_STEPS][NUM_CORES];
    logic [THREAD_TAG_WIDTH-1:0] step_thread [NUM_STEPS][NUM_CORES];

    io_data_t reg_model [NUM_IO_REGS];
    expect_t  expect_q [NUM_CORES][$];
    int       rr_ptr;
    int       cycle_count;
    int       check_count;
    int       error_count;
    int       seed;

    io_subsystem #(
        .NUM_CORES       (NUM_CORES),
        .THREADS_PER_CORE(THREADS_PER_CORE),
        .NUM_IO_REGS     (NUM_IO_REGS)
    ) dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_data(string name, io_data_t expected, io_data_t actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
        end
    endtask

    task automatic check_core(string name, logic [CORE_TAG_WIDTH-1:0] expected,
                              logic [CORE_TAG_WIDTH-1:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_thread(string name, logic [THREAD_TAG_WIDTH-1:0] expected,
                                logic [THREAD_TAG_WIDTH-1:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
        end
    endtask

    task automatic set_entry(int s, int c, io_op_t op, io_addr_t addr, io_data_t value, int thread);
        step_op[s][c] = op;
        step_address[s][c] = addr;
        step_value[s][c] = value;
        step_thread[s][c] = THREAD_TAG_WIDTH'(thread);
    endtask

    task automatic build_table();
        seed = 83453;
        // First every register is read once, all cores at a time
        for (int s = 0; s < RESET_STEPS; s++)
        begin
            step_mask[s] = '1;
            for (int c = 0; c < NUM_CORES; c++)
                set_entry(s, c, IO_READ, io_addr_t'(s * NUM_CORES + c), '0, c);
        end
        // Single write, then a read of the same register through an aliased address
        step_mask[RESET_STEPS] = NUM_CORES'(1);
        step_mask[RESET_STEPS + 1] = NUM_CORES'(4);
        for (int c = 0; c < NUM_CORES; c++)
        begin
            set_entry(RESET_STEPS, c, IO_WRITE, 16'd5, 32'hcafe_0005, 1);
            set_entry(RESET_STEPS + 1, c, IO_READ, io_addr_t'(5 + NUM_IO_REGS), '0, 3);
        end
        // All cores write one aliased register, then all read it back
        step_mask[RESET_STEPS + 2] = '1;
        step_mask[RESET_STEPS + 3] = '1;
        for (int c = 0; c < NUM_CORES; c++)
        begin
            set_entry(RESET_STEPS + 2, c, IO_WRITE, io_addr_t'(9 + NUM_IO_REGS * c),
                      32'h9000_0000 + io_data_t'(c), c);
            set_entry(RESET_STEPS + 3, c, IO_READ, io_addr_t'(9 + NUM_IO_REGS * (c + 4)), '0,
                      NUM_CORES - 1 - c);
        end
        // The rest of the table is random traffic with a random set of cores
        for (int s = RESET_STEPS + 4; s < NUM_STEPS; s++)
        begin
            step_mask[s] = NUM_CORES'($random(seed));
            if (step_mask[s] == '0)
                step_mask[s] = '1;
            for (int c = 0; c < NUM_CORES; c++)
                set_entry(s, c, ($random(seed) & 1) ? IO_WRITE : IO_READ,
                          io_addr_t'($random(seed)), io_data_t'($random(seed)), $random(seed));
        end
    endtask

    task automatic apply_requests(int s, logic [NUM_CORES-1:0] pending);
        request_valid = pending;
        for (int c = 0; c < NUM_CORES; c++)
        begin
            request_op[c] = step_op[s][c];
            request_address[c] = step_address[s][c];
            request_value[c] = step_value[s][c];
            request_thread[c] = step_thread[s][c];
        end
    endtask

    // Predicts the round-robin grant and records the response each grant owes
    task automatic check_grant();
        logic [NUM_CORES-1:0] expected_ready;
        int                   winner;
        int                   cand;
        int                   reg_idx;
        expect_t              entry;

        expected_ready = '0;
        winner = -1;
        for (int offset = 0; offset < NUM_CORES; offset++)
        begin
            cand = (rr_ptr + offset) % NUM_CORES;
            if (winner < 0 && request_valid[cand])
                winner = cand;
        end
        if (winner >= 0)
        begin
            expected_ready[winner] = 1'b1;
            rr_ptr = (winner + 1) % NUM_CORES;
        end
        for (int c = 0; c < NUM_CORES; c++)
        begin
            check_bit($sformatf("request_ready[%0d]", c), expected_ready[c], request_ready[c]);
            if (request_ready[c])
            begin
                // The model follows the bus order, so a read sees every earlier write
                reg_idx = int'(request_address[c]) % NUM_IO_REGS;
                entry.thread = request_thread[c];
                entry.cycle = cycle_count + 2;
                if (request_op[c] == IO_WRITE)
                begin
                    entry.value = '0;
                    reg_model[reg_idx] = request_value[c];
                end
                else
                    entry.value = reg_model[reg_idx];
                expect_q[c].push_back(entry);
            end
        end
    endtask

    // The core whose oldest entry falls due this cycle must be the one responding
    task automatic check_response();
        int      exp_core;
        expect_t entry;

        exp_core = -1;
        for (int c = 0; c < NUM_CORES; c++)
            if (expect_q[c].size() > 0 && expect_q[c][0].cycle == cycle_count)
                exp_core = c;
        check_bit("response_valid", exp_core >= 0, response_valid);
        if (exp_core >= 0)
        begin
            entry = expect_q[exp_core].pop_front();
            if (response_valid)
            begin
                check_core("response_core", CORE_TAG_WIDTH'(exp_core), response_core);
                check_thread("response_thread", entry.thread, response_thread);
                check_data("response_read_value", entry.value, response_read_value);
            end
        end
    endtask

    function automatic bit queues_pending();
        bit busy;

        busy = 1'b0;
        for (int c = 0; c < NUM_CORES; c++)
            if (expect_q[c].size() > 0)
                busy = 1'b1;
        return busy;
    endfunction

    // Outputs settle well before the falling edge, so all sampling happens there
    always @(negedge clk)
    begin
        if (!reset)
        begin
            cycle_count++;
            check_response();
            check_grant();
        end
    end

    initial
    begin : stimulus
        logic [NUM_CORES-1:0] pending;
        int                   wait_cycles;

        reset = 1'b1;
        rr_ptr = 0;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        for (int i = 0; i < NUM_IO_REGS; i++)
            reg_model[i] = '0;
        build_table();
        apply_requests(0, '0);
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;

        for (int s = 0; s < NUM_STEPS; s++)
        begin
            pending = step_mask[s];
            wait_cycles = 0;
            // Each core holds its request until the cycle that shows its ready bit
            while (pending != '0 && wait_cycles < STEP_TIMEOUT)
            begin
                @(posedge clk);
                #5;
                apply_requests(s, pending);
                @(negedge clk);
                pending = pending & ~request_ready;
                wait_cycles++;
            end
            if (pending != '0)
            begin
                $display("Step %0d timed out with cores %b never granted", s, pending);
                $display("Checks: %0d, errors: %0d", check_count, error_count + 1);
                $display("Testbench failed");
                $finish;
            end
        end
        @(posedge clk);
        #5;
        request_valid = '0;

        wait_cycles = 0;
        while (queues_pending() && wait_cycles < DRAIN_TIMEOUT)
        begin
            @(negedge clk);
            wait_cycles++;
        end
        if (queues_pending())
            error_count++;
        if (queues_pending())
            $display("Responses still outstanding after %0d drain cycles", DRAIN_TIMEOUT);
        // A few idle cycles catch any late or duplicated response
        repeat (4) @(negedge clk);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// File: io_subsystem.f
hw/io_pkg.sv
hw/rr_arbiter.sv
hw/io_interconnect.sv
hw/io_register_bank.sv
hw/io_subsystem.sv
sim/io_subsystem_props.sv
sim/io_subsystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the IO subsystem simulation with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module io_subsystem_tb \
    -f io_subsystem.f \
    -o io_subsystem_sim

./obj_dir/io_subsystem_sim | tee sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "run_sim: simulation passed"
else
    echo "run_sim: simulation failed"
    exit 1
fi
